/* common/ucode_pkg.sv */
// ===========================================================================
// Shared definitions for the microcoded multiplier
//   widths of data, register address, immediate and flags
//   instruction opcodes and the NOP word
//   sequencer states and multiply types
// ===========================================================================
`default_nettype none

package ucode_pkg;

    localparam int DATA_W   = 32;   // Datapath width
    localparam int REG_AW   = 4;    // 16 registers
    localparam int IMM_W    = 16;   // Immediate field width
    localparam int FLAG_W   = 4;    // N Z C V
    localparam int NUM_REGS = 1 << REG_AW;

    // Seven-bit opcodes, instruction bits 31..25
    typedef enum logic [6:0] {
        MOV  = 7'b0000000,          // Rd <= sext(imm16)
        ADD  = 7'b0110001,
        SUB  = 7'b0110010,
        SUBI = 7'b0010010,          // Rd <= Rs1 - sext(imm16)
        SUBS = 7'b0111010,          // Flag-setting subtract
        ADDS = 7'b0111001,          // Flag-setting add
        NOT  = 7'b0110110
    } opcode_t;

    // Bubble presented when nothing valid is fetched
    localparam logic [DATA_W-1:0] NOP_WORD = {5'b11001, 27'b0};

    typedef enum logic [2:0] {
        S_IDLE,
        S_CLEAR,                    // Zero multiplier, single SUBS
        S_MOV,                      // Clear Rd before the additions
        S_ADD,
        S_FIX_DEC,                  // Negate step one, Rd - 1
        S_FIX_NOT,                  // Negate step two, invert
        S_HALT
    } ucode_state_t;

    typedef enum logic [1:0] {
        MULI  = 2'd0,
        MULR  = 2'd1,
        MULSI = 2'd2,
        MULSR = 2'd3
    } mul_type_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the multiplier testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_mul_core -f tb.f -o sim_mul_core \
    && ./obj_dir/sim_mul_core | tee sim.log \
    || { echo "build or run error"; exit 1; }
grep -q "all tests passed" sim.log && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }

/* source/exec_unit.sv */
// ===========================================================================
// Minimal execute unit
//   16 x 32 register file with reset
//   MOV, ADD, ADDS, SUB, SUBS, SUBI, NOT and NZCV flags
//   operand read port for the multiplier, debug read port
// ===========================================================================
`default_nettype none

module exec_unit
    import ucode_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [DATA_W-1:0] exec_instr,
    input  logic              exec_valid,
    input  logic [FLAG_W-1:0] flags_restore,
    input  logic              restore_en,
    input  logic [REG_AW-1:0] mult_reg,
    input  logic [REG_AW-1:0] dbg_addr,
    output logic [DATA_W-1:0] operand_data,
    output logic [DATA_W-1:0] dbg_data,
    output logic [FLAG_W-1:0] alu_flags     // {N, Z, C, V}
);

    logic [DATA_W-1:0] regs [NUM_REGS];
    opcode_t           op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [DATA_W-1:0] src_a;
    logic [DATA_W-1:0] src_b;
    logic [DATA_W-1:0] imm_ext;
    logic [DATA_W-1:0] sub_b;
    logic [DATA_W:0]   sum_w;               // Carry in the top bit
    logic [DATA_W:0]   diff_w;              // Top bit set means no borrow
    logic [DATA_W-1:0] result;
    logic              wr_en;
    logic              set_flags;
    logic [FLAG_W-1:0] flags_d;

    // Field decode
    assign op      = opcode_t'(exec_instr[31:25]);
    assign rd      = exec_instr[24:21];
    assign rs1     = exec_instr[20:17];
    assign rs2     = exec_instr[16:13];
    assign imm_ext = {{(DATA_W-IMM_W){exec_instr[IMM_W-1]}}, exec_instr[IMM_W-1:0]};

    assign src_a = regs[rs1];
    assign src_b = regs[rs2];
    assign sub_b = (op == SUBI) ? imm_ext : src_b;

    assign sum_w  = {1'b0, src_a} + {1'b0, src_b};
    assign diff_w = {1'b0, src_a} + {1'b0, ~sub_b} + 1'b1;

    always_comb begin
        result    = '0;
        wr_en     = 1'b0;
        set_flags = 1'b0;
        flags_d   = alu_flags;
        case (op)
            MOV:       begin result = imm_ext;           wr_en = exec_valid; end
            ADD:       begin result = sum_w[DATA_W-1:0];  wr_en = exec_valid; end
            SUB, SUBI: begin result = diff_w[DATA_W-1:0]; wr_en = exec_valid; end
            NOT:       begin result = ~src_a;            wr_en = exec_valid; end
            ADDS: begin
                result    = sum_w[DATA_W-1:0];
                wr_en     = exec_valid;
                set_flags = exec_valid;
                flags_d   = {result[DATA_W-1], result == '0, sum_w[DATA_W],
                             (src_a[DATA_W-1] == src_b[DATA_W-1]) &&
                             (result[DATA_W-1] != src_a[DATA_W-1])};
            end
            SUBS: begin
                result    = diff_w[DATA_W-1:0];
                wr_en     = exec_valid;
                set_flags = exec_valid;
                flags_d   = {result[DATA_W-1], result == '0, diff_w[DATA_W],
                             (src_a[DATA_W-1] != src_b[DATA_W-1]) &&
                             (result[DATA_W-1] != src_a[DATA_W-1])};
            end
            default: ;                      // NOP and unknown words
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
        end else if (wr_en) begin
            regs[rd] <= result;
        end
    end

    // A flag-setting op in the release cycle is younger than the restore
    always_ff @(posedge clk or posedge rst) begin
        if (rst)             alu_flags <= '0;
        else if (set_flags)  alu_flags <= flags_d;
        else if (restore_en) alu_flags <= flags_restore;
    end

    assign operand_data = regs[mult_reg];   // MULR multiplier
    assign dbg_data     = regs[dbg_addr];

endmodule

`default_nettype wire

/* source/mul_core.sv */
// ===========================================================================
// Microcoded multiplier top level
//   sequencer, multiplier counter, slot mux and execute unit
// ===========================================================================
`default_nettype none

module mul_core
    import ucode_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start_mul,    // One-cycle decode strobe
    input  logic [REG_AW-1:0] dest_reg,
    input  logic [REG_AW-1:0] source_reg,
    input  logic [REG_AW-1:0] mult_reg,
    input  logic [IMM_W-1:0]  immediate,
    input  mul_type_t         mul_type,
    input  logic [DATA_W-1:0] fetch_instr,
    input  logic              fetch_valid,
    input  logic [REG_AW-1:0] dbg_addr,
    output logic [DATA_W-1:0] dbg_data,
    output logic              busy,         // Fetch stall
    output logic              mul_release,
    output logic [FLAG_W-1:0] flags
);

    logic [DATA_W-1:0] uop_instr;
    logic              load_count;
    logic              dec_count;
    logic              count_zero;
    logic              last_add;
    logic              mult_neg;
    logic [DATA_W-1:0] operand_data;
    logic [DATA_W-1:0] exec_instr;
    logic              exec_valid;
    logic [FLAG_W-1:0] flags_restore;
    logic              restore_en;

    ucode_ctrl ucode_ctrl_inst (
        .clk, .rst, .start_mul, .dest_reg, .source_reg, .mul_type,
        .count_zero, .last_add, .mult_neg, .uop_instr,
        .uop_sel     (busy),                // Busy is the inject select
        .load_count, .dec_count, .mul_release
    );

    mul_counter mul_counter_inst (
        .clk, .rst, .load_count, .dec_count, .immediate, .operand_data,
        .mul_type, .count_zero, .last_add, .mult_neg
    );

    inject_mux inject_mux_inst (
        .clk, .rst,
        .uop_sel     (busy),
        .uop_instr, .fetch_instr, .fetch_valid, .start_mul, .mul_type,
        .mul_release,
        .alu_flags   (flags),
        .exec_instr, .exec_valid, .flags_restore, .restore_en
    );

    exec_unit exec_unit_inst (
        .clk, .rst, .exec_instr, .exec_valid, .flags_restore, .restore_en,
        .mult_reg, .dbg_addr, .operand_data, .dbg_data,
        .alu_flags   (flags)
    );

endmodule

`default_nettype wire

/* tb.f */
common/ucode_pkg.sv
ucode/ucode_ctrl.sv
ucode/mul_counter.sv
ucode/inject_mux.sv
source/exec_unit.sv
source/mul_core.sv
testbench/tb_clock.sv
testbench/tb_mul_core.sv

/* testbench/tb_clock.sv */
// ===========================================================================
// Testbench clock and reset
//   40 ns clock, reset held high for the first 4 cycles
// ===========================================================================
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;                // Released on a rising edge
    end

endmodule

`default_nettype wire

/* testbench/tb_mul_core.sv */
// ===========================================================================
// Testbench for the microcoded multiplier
//   register preload over the fetch path, reference model of regs/flags
//   directed and random MULI, MULR, MULSI, MULSR sequences
//   result, busy length, release pulse and flag assertions
// ===========================================================================
`default_nettype none

module tb_mul_core
    import ucode_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic              clk;
    logic              rst;
    logic              start_mul;
    logic [REG_AW-1:0] dest_reg;
    logic [REG_AW-1:0] source_reg;
    logic [REG_AW-1:0] mult_reg;
    logic [IMM_W-1:0]  immediate;
    mul_type_t         mul_type;
    logic [DATA_W-1:0] fetch_instr;
    logic              fetch_valid;
    logic [REG_AW-1:0] dbg_addr;
    logic [DATA_W-1:0] dbg_data;
    logic              busy;
    logic              mul_release;
    logic [FLAG_W-1:0] flags;

    logic [DATA_W-1:0] model_regs [NUM_REGS];   // Expected register file
    logic [FLAG_W-1:0] model_flags;             // Expected NZCV
    int                errors;
    int                checks;
    integer            seed;

    tb_clock tb_clock_inst (.clk, .rst);

    mul_core mul_core_inst (
        .clk, .rst, .start_mul, .dest_reg, .source_reg, .mult_reg, .immediate,
        .mul_type, .fetch_instr, .fetch_valid, .dbg_addr, .dbg_data, .busy,
        .mul_release, .flags
    );

    // NZCV of a + b
    function automatic logic [FLAG_W-1:0] add_flags(input logic [DATA_W-1:0] a,
                                                    input logic [DATA_W-1:0] b);
        logic [DATA_W:0]        s;
        logic signed [DATA_W:0] ss;
        s  = {1'b0, a} + {1'b0, b};
        ss = $signed({a[DATA_W-1], a}) + $signed({b[DATA_W-1], b});
        // Overflow when the signed sum leaves the 32-bit range
        return {s[DATA_W-1], s[DATA_W-1:0] == '0, s[DATA_W], ss[DATA_W] != ss[DATA_W-1]};
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
        checks++;
        assert (act === exp) else begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // One fetched word, presented for a single cycle
    task automatic fetch_word(input logic [DATA_W-1:0] word);
        @(posedge clk);
        fetch_instr <= word;
        fetch_valid <= 1'b1;
        @(posedge clk);
        fetch_valid <= 1'b0;
        fetch_instr <= NOP_WORD;
    endtask

    task automatic load_reg(input logic [REG_AW-1:0] r, input logic [IMM_W-1:0] val);
        fetch_word({MOV, r, 5'b0, val});
        model_regs[r] = {{(DATA_W-IMM_W){val[IMM_W-1]}}, val};
    endtask

    // Flags from an ADDS R13,R14,R15 on the fetch path
    task automatic set_flags(input logic [IMM_W-1:0] a, input logic [IMM_W-1:0] b);
        load_reg(14, a);
        load_reg(15, b);
        fetch_word({ADDS, 4'd13, 4'd14, 4'd15, 13'b0});
        model_flags    = add_flags(model_regs[14], model_regs[15]);
        model_regs[13] = model_regs[14] + model_regs[15];
    endtask

    task automatic check_reg(input logic [REG_AW-1:0] r);
        @(posedge clk);
        dbg_addr <= r;
        @(negedge clk);             // Debug read is combinational
        check_value($sformatf("dbg_data R%0d", r), model_regs[r], dbg_data);
    endtask

    task automatic run_mul(input mul_type_t t, input logic [REG_AW-1:0] rd,
                           input logic [REG_AW-1:0] rs, input logic [REG_AW-1:0] rm,
                           input logic [IMM_W-1:0] imm);
        logic signed [DATA_W-1:0] m;
        logic [DATA_W-1:0]        mag;
        logic [DATA_W-1:0]        acc;
        logic [FLAG_W-1:0]        exp_flags;
        logic                     s_type;
        int                       exp_busy;
        int                       busy_cnt;
        int                       wait_cnt;
        s_type = (t == MULSI || t == MULSR);
        m   = (t == MULI || t == MULSI) ? {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm} : model_regs[rm];
        mag = (m < 0) ? -m : m;
        exp_busy  = (m == 0) ? 1 : ((m < 0) ? 3 + int'(mag) : 1 + int'(mag));
        exp_flags = model_flags;    // Plain types keep the old flags
        acc = '0;
        for (int i = 0; i < int'(mag); i++) begin
            if (s_type) exp_flags = add_flags(acc, model_regs[rs]);
            acc = acc + model_regs[rs];
        end
        if (m == 0 && s_type) exp_flags = 4'b0110;   // Rd - Rd, zero and no borrow
        model_regs[rd] = model_regs[rs] * m;
        model_flags    = exp_flags;

        @(posedge clk);
        start_mul  <= 1'b1;
        mul_type   <= t;
        dest_reg   <= rd;
        source_reg <= rs;
        mult_reg   <= rm;
        immediate  <= imm;
        dbg_addr   <= rd;           // Watch the destination
        @(posedge clk);
        start_mul <= 1'b0;
        busy_cnt = 0;
        wait_cnt = 0;
        @(negedge clk);             // First injected cycle
        while (!mul_release && wait_cnt < 200) begin
            if (busy) busy_cnt++;
            wait_cnt++;
            @(negedge clk);
        end
        if (!mul_release) begin
            $display("Timeout: no mul_release within 200 cycles for %s", t.name());
            errors++;
        end else begin
            check_value("busy", '0, 32'(busy));          // Low in release cycle
            check_value("busy cycles", exp_busy, busy_cnt);
            @(negedge clk);
            check_value("mul_release", '0, 32'(mul_release));  // One-cycle pulse
            check_value("flags", 32'(exp_flags), 32'(flags));
            check_value($sformatf("dbg_data R%0d", rd), model_regs[rd], dbg_data);
        end
    endtask

    initial begin
        integer                   rnd;
        logic signed [DATA_W-1:0] src_v;
        logic signed [DATA_W-1:0] mul_v;
        errors = 0;
        checks = 0;
        seed   = 88;
        start_mul   <= 1'b0;
        dest_reg    <= '0;
        source_reg  <= '0;
        mult_reg    <= '0;
        immediate   <= '0;
        mul_type    <= MULI;
        fetch_instr <= NOP_WORD;
        fetch_valid <= 1'b0;
        dbg_addr    <= '0;
        for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
        model_flags = '0;

        repeat (6) @(negedge clk);  // Reset is 4 cycles
        check_value("busy", '0, 32'(busy));
        check_value("mul_release", '0, 32'(mul_release));
        check_value("flags", '0, 32'(flags));

        // Preload over fetch and read back
        load_reg(1, 16'd25);
        load_reg(2, 16'(-37));
        load_reg(3, 16'd0);
        load_reg(4, 16'(-6));
        load_reg(6, 16'd9);
        check_reg(1);
        check_reg(2);
        check_reg(3);
        check_reg(4);
        check_reg(6);

        set_flags(16'(-5), 16'd3);                  // N set
        run_mul(MULI, 5, 1, 0, 16'd7);
        run_mul(MULI, 5, 2, 0, 16'd0);
        run_mul(MULI, 7, 2, 0, 16'(-4));
        run_mul(MULI, 7, 1, 0, 16'(-1));
        set_flags(16'(-1), 16'(-1));                // N and C set
        run_mul(MULR, 8, 1, 3, 16'd0);              // Zero register
        run_mul(MULR, 8, 2, 4, 16'd0);
        run_mul(MULR, 9, 1, 6, 16'd0);
        load_reg(2, 16'd700);                       // Fetch between multiplies
        check_reg(2);
        run_mul(MULSI, 10, 2, 0, 16'd13);
        run_mul(MULSI, 10, 1, 0, 16'd0);
        run_mul(MULSR, 11, 2, 4, 16'd0);
        run_mul(MULSR, 11, 4, 6, 16'd0);            // Negative sums

        // Random types and operands
        for (int n = 0; n < 16; n++) begin
            src_v = $random(seed) % 1001;
            mul_v = $random(seed) % 21;
            rnd   = $random(seed);
            load_reg(11, src_v[IMM_W-1:0]);
            load_reg(12, mul_v[IMM_W-1:0]);
            set_flags(rnd[15:0], rnd[31:16]);
            rnd = $random(seed);
            run_mul(mul_type_t'(rnd[1:0]), 10, 11, 12, mul_v[IMM_W-1:0]);
            check_reg(11);                          // Source left intact
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ucode/inject_mux.sv */
// ===========================================================================
// Execute slot mux and flag save/restore
//   injected word while busy, else fetched word or NOP
//   flags saved at the multiply strobe, restored on release
// ===========================================================================
`default_nettype none

module inject_mux
    import ucode_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              uop_sel,
    input  logic [DATA_W-1:0] uop_instr,
    input  logic [DATA_W-1:0] fetch_instr,
    input  logic              fetch_valid,
    input  logic              start_mul,
    input  mul_type_t         mul_type,
    input  logic              mul_release,
    input  logic [FLAG_W-1:0] alu_flags,
    output logic [DATA_W-1:0] exec_instr,
    output logic              exec_valid,
    output logic [FLAG_W-1:0] flags_restore,
    output logic              restore_en
);

    logic [FLAG_W-1:0] saved_flags_q;
    logic              plain_q;          // Plain multiply, flags come back
    logic              take_mul;

    // Same acceptance window as the sequencer's idle state
    assign take_mul = start_mul && !uop_sel && !mul_release;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            plain_q <= 1'b0;
        end else if (take_mul) begin
            plain_q <= (mul_type == MULI || mul_type == MULR);
        end
    end

    always_ff @(posedge clk) begin
        if (take_mul) saved_flags_q <= alu_flags;   // Flags before the sequence
    end

    assign flags_restore = saved_flags_q;
    assign restore_en    = mul_release && plain_q;

    // Fetch is stalled by busy, injected word has priority
    assign exec_instr = uop_sel     ? uop_instr   :
                        fetch_valid ? fetch_instr : NOP_WORD;
    assign exec_valid = uop_sel || fetch_valid;

endmodule

`default_nettype wire

/* ucode/mul_counter.sv */
// ===========================================================================
// Multiplier down-counter
//   picks immediate or register multiplier, keeps magnitude and sign,
//   counts down one per injected addition
// ===========================================================================
`default_nettype none

module mul_counter
    import ucode_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              load_count,
    input  logic              dec_count,
    input  logic [IMM_W-1:0]  immediate,
    input  logic [DATA_W-1:0] operand_data,  // Register multiplier
    input  mul_type_t         mul_type,
    output logic              count_zero,
    output logic              last_add,
    output logic              mult_neg
);

    logic [DATA_W-1:0] mult_val;
    logic [DATA_W-1:0] mult_mag;
    logic [DATA_W-1:0] count_q;

    // Immediate types sign-extend imm16
    assign mult_val = (mul_type == MULI || mul_type == MULSI) ?
                      {{(DATA_W-IMM_W){immediate[IMM_W-1]}}, immediate} :
                      operand_data;

    assign mult_mag = mult_val[DATA_W-1] ? (~mult_val + 1'b1) : mult_val;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_q  <= '0;
            mult_neg <= 1'b0;
        end else if (load_count) begin
            count_q  <= mult_mag;
            mult_neg <= mult_val[DATA_W-1];
        end else if (dec_count && !count_zero) begin
            count_q <= count_q - 1'b1;      // One per ADD
        end
    end

    assign count_zero = (count_q == '0);
    assign last_add   = (count_q == DATA_W'(1));   // This ADD is the final one

endmodule

`default_nettype wire

/* ucode/ucode_ctrl.sv */
// ===========================================================================
// Microcode sequencer FSM
//   takes the execute slot on a multiply strobe and injects
//   MOV / ADD(S) / SUBI / NOT / SUBS words, then releases the slot
// ===========================================================================
`default_nettype none

module ucode_ctrl
    import ucode_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start_mul,
    input  logic [REG_AW-1:0] dest_reg,
    input  logic [REG_AW-1:0] source_reg,
    input  mul_type_t         mul_type,
    input  logic              count_zero,   // From the freshly loaded counter
    input  logic              last_add,
    input  logic              mult_neg,
    output logic [DATA_W-1:0] uop_instr,
    output logic              uop_sel,      // High while injecting
    output logic              load_count,
    output logic              dec_count,
    output logic              mul_release
);

    ucode_state_t      state_q;
    ucode_state_t      state_d;
    ucode_state_t      act_state;           // State after the zero decision
    logic [REG_AW-1:0] rd_q;
    logic [REG_AW-1:0] rs_q;
    mul_type_t         type_q;
    logic              neg_fix_q;           // Result needs negating
    opcode_t           add_op;

    // Count is only valid one cycle after the strobe, so the first
    // injected cycle resolves into the clear path here
    assign act_state = (state_q == S_MOV && count_zero) ? S_CLEAR : state_q;

    // S types keep flags from the additions
    assign add_op = (type_q == MULSI || type_q == MULSR) ? ADDS : ADD;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= S_IDLE;
            neg_fix_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (act_state == S_MOV) begin
                neg_fix_q <= mult_neg;  // Sign is settled by now
            end
        end
    end

    // Operand fields captured with the strobe
    always_ff @(posedge clk) begin
        if (load_count) begin
            rd_q   <= dest_reg;
            rs_q   <= source_reg;
            type_q <= mul_type;
        end
    end

    always_comb begin
        state_d     = state_q;
        uop_instr   = NOP_WORD;
        uop_sel     = 1'b0;
        load_count  = 1'b0;
        dec_count   = 1'b0;
        mul_release = 1'b0;
        case (act_state)
            S_IDLE: begin
                if (start_mul) begin
                    load_count = 1'b1;   // Counter grabs magnitude and sign
                    state_d    = S_MOV;
                end
            end
            S_CLEAR: begin
                uop_sel   = 1'b1;
                uop_instr = {SUBS, rd_q, rd_q, rd_q, 13'b0};   // Rd - Rd
                state_d   = S_HALT;
            end
            S_MOV: begin
                uop_sel   = 1'b1;
                uop_instr = {MOV, rd_q, 5'b0, 16'h0000};       // Rd <= 0
                state_d   = S_ADD;
            end
            S_ADD: begin
                uop_sel   = 1'b1;
                dec_count = 1'b1;
                uop_instr = {add_op, rd_q, rd_q, rs_q, 13'b0};
                if (last_add) begin
                    state_d = neg_fix_q ? S_FIX_DEC : S_HALT;
                end
            end
            S_FIX_DEC: begin
                uop_sel   = 1'b1;
                uop_instr = {SUBI, rd_q, rd_q, 1'b0, 16'h0001};
                state_d   = S_FIX_NOT;
            end
            S_FIX_NOT: begin
                uop_sel   = 1'b1;
                uop_instr = {NOT, rd_q, rd_q, 17'b0};         // ~(x - 1) = -x
                state_d   = S_HALT;
            end
            S_HALT: begin
                mul_release = 1'b1;      // Slot back to fetch
                state_d     = S_IDLE;
            end
            default: state_d = S_IDLE;
        endcase
    end

endmodule

`default_nettype wire
